// File: csrSubsystem.f
logic/csrPkg.sv
logic/csrAccessIf.sv
logic/csrWishbone.sv
logic/csrMachine.sv
logic/csrStatus.sv
logic/csrTop.sv
tests/csrTb_asserts.sv
tests/csrTb.sv

// File: logic/csrAccessIf.sv
`timescale 1ns/1ps

interface csrAccessIf;

  // Access request from the bus side
  logic           req;
  logic           write;
  csrPkg::csrAdr  adr;
  csrPkg::csrWord wrData;
  // Combinational reply from the register side
  csrPkg::csrWord rdData;
  logic           illegal;

  // Bus slave starts the access
  modport bus (output req, write, adr, wrData, input rdData, illegal);

  // CSR registers decode it and answer
  modport regs (input req, write, adr, wrData, output rdData, illegal);

  // Status block only needs the write data
  modport observe (input wrData);

endinterface

// File: logic/csrMachine.sv
`timescale 1ns/1ps

module csrMachine (
  input  logic           clk,
  input  logic           rstN,
  input  logic           trap,
  input  csrPkg::csrWord nextEpc,
  input  logic [4:0]     nextCause,
  input  csrPkg::csrWord nextTval,
  input  csrPkg::csrWord mstatusVal,
  input  logic [11:0]    mieVal,
  input  logic [11:0]    mip,
  csrAccessIf.regs       acc,
  output logic           writeStatus,
  output logic           writeIe,
  output csrPkg::csrWord mtvec,
  output csrPkg::csrWord mepc
);

  csrPkg::csrWord    mscratch;
  csrPkg::csrWord    mcause;
  csrPkg::csrWord    mtval;
  csrPkg::csrWord    mcounteren;
  csrPkg::csrWord    mcountinhibit;
  logic [15:0]       medeleg;
  logic [11:0]       mideleg;
  csrPkg::pmpCfgWord pmpCfg;
  csrPkg::pmpCfgWord cfgWrite;
  logic [csrPkg::paBits-3:0] pmpAddr [csrPkg::pmpEntries];

  logic wrEn;
  logic wrMtvec;
  logic wrMscratch;
  logic wrMedeleg;
  logic wrMideleg;
  logic wrMepc;
  logic wrMcause;
  logic wrMtval;
  logic wrMcounteren;
  logic wrMcountinhibit;
  logic wrPmpcfg;
  logic [csrPkg::pmpEntries-1:0] wrPmpaddr;
  logic [csrPkg::pmpEntries-1:0] cfgLocked;
  logic [csrPkg::pmpEntries-1:0] addrLocked;
  logic                                  pmpHit;
  logic [$clog2(csrPkg::pmpEntries)-1:0] pmpIdx;

  ////////////////////////////////////////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////////////////////////////////////////

  // Illegal accesses never write
  assign wrEn = acc.req & acc.write & ~acc.illegal;

  assign writeStatus     = wrEn & (acc.adr == csrPkg::adrMstatus);
  assign writeIe         = wrEn & (acc.adr == csrPkg::adrMie);
  assign wrMtvec         = wrEn & (acc.adr == csrPkg::adrMtvec);
  assign wrMscratch      = wrEn & (acc.adr == csrPkg::adrMscratch);
  assign wrMedeleg       = wrEn & (acc.adr == csrPkg::adrMedeleg);
  assign wrMideleg       = wrEn & (acc.adr == csrPkg::adrMideleg);
  assign wrMepc          = wrEn & (acc.adr == csrPkg::adrMepc);
  assign wrMcause        = wrEn & (acc.adr == csrPkg::adrMcause);
  assign wrMtval         = wrEn & (acc.adr == csrPkg::adrMtval);
  assign wrMcounteren    = wrEn & (acc.adr == csrPkg::adrMcounteren);
  assign wrMcountinhibit = wrEn & (acc.adr == csrPkg::adrMcountinhibit);
  assign wrPmpcfg        = wrEn & (acc.adr == csrPkg::adrPmpcfg0);

  // Low address bits of the aligned pmpaddr block pick the entry
  assign pmpHit = (acc.adr >= csrPkg::adrPmpaddr0) &&
                  (acc.adr < csrPkg::adrPmpaddr0 + csrPkg::pmpEntries);
  assign pmpIdx = acc.adr[$clog2(csrPkg::pmpEntries)-1:0];

  // Reserved bits of each written byte read as zero
  always_comb begin
    cfgWrite.raw = acc.wrData;
    for (int i = 0; i < csrPkg::pmpEntries; i++) begin
      cfgWrite.entry[i].rsvd = 2'b00;
    end
  end

  // Lock rules per entry
  for (genvar i = 0; i < csrPkg::pmpEntries; i++) begin : genLock
    assign cfgLocked[i] = pmpCfg.entry[i].lock;
    if (i == csrPkg::pmpEntries - 1) begin : genLast
      assign addrLocked[i] = cfgLocked[i];
    end else begin : genNext
      // Locked TOR entry above also pins this address
      assign addrLocked[i] = cfgLocked[i] |
        (pmpCfg.entry[i+1].lock & (pmpCfg.entry[i+1].addrMode == csrPkg::tor));
    end
    assign wrPmpaddr[i] = wrEn & pmpHit & (pmpIdx == i) & ~addrLocked[i];
  end

  ////////////////////////////////////////////////////////////////////////////
  // Registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mtvec         <= '0;
      mscratch      <= '0;
      medeleg       <= '0;
      mideleg       <= '0;
      mepc          <= '0;
      mcause        <= '0;
      mtval         <= '0;
      mcounteren    <= '0;
      mcountinhibit <= '0;
      pmpCfg        <= '0;
      for (int i = 0; i < csrPkg::pmpEntries; i++) begin
        pmpAddr[i] <= '0;
      end
    end else begin
      // Bit 1 of mtvec is reserved
      if (wrMtvec)         mtvec <= {acc.wrData[31:2], 1'b0, acc.wrData[0]};
      if (wrMscratch)      mscratch <= acc.wrData;
      if (wrMedeleg)       medeleg <= acc.wrData[15:0] & csrPkg::medelegMask;
      if (wrMideleg)       mideleg <= acc.wrData[11:0] & csrPkg::midelegMask;
      if (wrMcounteren)    mcounteren <= acc.wrData;
      if (wrMcountinhibit) mcountinhibit <= acc.wrData;
      // Trap wins over a bus write in the same cycle
      if (trap) begin
        mepc   <= nextEpc;
        mcause <= {nextCause[4], 27'b0, nextCause[3:0]};
        mtval  <= nextTval;
      end else begin
        if (wrMepc)   mepc <= acc.wrData;
        if (wrMcause) mcause <= acc.wrData;
        if (wrMtval)  mtval <= acc.wrData;
      end
      for (int i = 0; i < csrPkg::pmpEntries; i++) begin
        if (wrPmpcfg && !cfgLocked[i]) pmpCfg.entry[i] <= cfgWrite.entry[i];
        if (wrPmpaddr[i]) pmpAddr[i] <= acc.wrData[csrPkg::paBits-3:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Read mux and illegal detection
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    acc.rdData  = '0;
    acc.illegal = 1'b0;
    if (pmpHit) begin
      acc.rdData = csrPkg::csrWord'(pmpAddr[pmpIdx]);
    end else begin
      case (acc.adr)
        csrPkg::adrMisa:          acc.rdData = csrPkg::misaValue;
        // Identity registers reject writes
        csrPkg::adrMvendorid,
        csrPkg::adrMarchid,
        csrPkg::adrMhartid:       acc.illegal = acc.write;
        csrPkg::adrMimpid: begin
          acc.rdData  = csrPkg::mimpidValue;
          acc.illegal = acc.write;
        end
        csrPkg::adrMstatus:       acc.rdData = mstatusVal;
        csrPkg::adrMedeleg:       acc.rdData = csrPkg::csrWord'(medeleg);
        csrPkg::adrMideleg:       acc.rdData = csrPkg::csrWord'(mideleg);
        csrPkg::adrMie:           acc.rdData = csrPkg::csrWord'(mieVal);
        csrPkg::adrMip:           acc.rdData = csrPkg::csrWord'(mip);
        csrPkg::adrMtvec:         acc.rdData = mtvec;
        csrPkg::adrMcounteren:    acc.rdData = mcounteren;
        csrPkg::adrMcountinhibit: acc.rdData = mcountinhibit;
        csrPkg::adrMscratch:      acc.rdData = mscratch;
        csrPkg::adrMepc:          acc.rdData = mepc;
        csrPkg::adrMcause:        acc.rdData = mcause;
        csrPkg::adrMtval:         acc.rdData = mtval;
        csrPkg::adrPmpcfg0:       acc.rdData = pmpCfg.raw;
        default:                  acc.illegal = 1'b1;
      endcase
    end
  end

endmodule

// File: logic/csrPkg.sv
package csrPkg;

  ////////////////////////////////////////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////////////////////////////////////////

  localparam int xlen       = 32;
  localparam int pmpEntries = 4;
  // Physical address width, pmpaddr holds bits paBits-1:2
  localparam int paBits     = 34;

  typedef logic [11:0]     csrAdr;
  typedef logic [xlen-1:0] csrWord;

  ////////////////////////////////////////////////////////////////////////////
  // Machine CSR addresses
  ////////////////////////////////////////////////////////////////////////////

  // Identity registers, read only
  localparam csrAdr adrMvendorid     = 12'hF11;
  localparam csrAdr adrMarchid       = 12'hF12;
  localparam csrAdr adrMimpid        = 12'hF13;
  localparam csrAdr adrMhartid       = 12'hF14;
  // Trap setup
  localparam csrAdr adrMstatus       = 12'h300;
  localparam csrAdr adrMisa          = 12'h301;
  localparam csrAdr adrMedeleg       = 12'h302;
  localparam csrAdr adrMideleg       = 12'h303;
  localparam csrAdr adrMie           = 12'h304;
  localparam csrAdr adrMtvec         = 12'h305;
  localparam csrAdr adrMcounteren    = 12'h306;
  localparam csrAdr adrMcountinhibit = 12'h320;
  // Trap handling
  localparam csrAdr adrMscratch      = 12'h340;
  localparam csrAdr adrMepc          = 12'h341;
  localparam csrAdr adrMcause        = 12'h342;
  localparam csrAdr adrMtval         = 12'h343;
  localparam csrAdr adrMip           = 12'h344;
  // PMP, entries follow pmpaddr0 at consecutive addresses
  localparam csrAdr adrPmpcfg0       = 12'h3A0;
  localparam csrAdr adrPmpaddr0      = 12'h3B0;

  ////////////////////////////////////////////////////////////////////////////
  // Constants and masks
  ////////////////////////////////////////////////////////////////////////////

  // MXL=1 for RV32, I and S extension bits
  localparam csrWord      misaValue   = 32'h4004_0100;
  localparam csrWord      mimpidValue = 32'h0000_0100;
  localparam logic [15:0] medelegMask = 16'hB3FF;
  // Only supervisor interrupts can be delegated
  localparam logic [11:0] midelegMask = 12'h222;
  // Machine mode privilege loaded into MPP on trap
  localparam logic [1:0]  mretLoad    = 2'd3;

  // PMP address matching modes
  typedef enum logic [1:0] {off = 2'd0, tor = 2'd1, na4 = 2'd2, napot = 2'd3} pmpAddrMode;

  // One pmpcfg byte
  typedef struct packed {
    logic       lock;
    logic [1:0] rsvd;
    pmpAddrMode addrMode;
    logic       x;
    logic       w;
    logic       r;
  } pmpCfgByte;

  // pmpcfg0 as a data word or as per-entry bytes, entry 0 in the low byte
  typedef union packed {
    csrWord                       raw;
    pmpCfgByte [pmpEntries-1:0]   entry;
  } pmpCfgWord;

endpackage

// File: logic/csrStatus.sv
`timescale 1ns/1ps

module csrStatus (
  input  logic           clk,
  input  logic           rstN,
  input  logic           trap,
  input  logic           mret,
  input  logic           writeStatus,
  input  logic           writeIe,
  csrAccessIf.observe    acc,
  output csrPkg::csrWord mstatusVal,
  output logic [11:0]    mieVal,
  output logic           globalIntEn
);

  logic       statMie;
  logic       statMpie;
  logic [1:0] statMpp;

  ////////////////////////////////////////////////////////////////////////////
  // mstatus fields
  ////////////////////////////////////////////////////////////////////////////

  // Trap first, then mret, then bus write
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      statMie  <= 1'b0;
      statMpie <= 1'b0;
      statMpp  <= 2'b00;
    end else if (trap) begin
      statMpie <= statMie;
      statMie  <= 1'b0;
      statMpp  <= csrPkg::mretLoad;
    end else if (mret) begin
      statMie  <= statMpie;
      statMpie <= 1'b1;
    end else if (writeStatus) begin
      // Only MIE, MPIE and MPP exist
      statMie  <= acc.wrData[3];
      statMpie <= acc.wrData[7];
      statMpp  <= acc.wrData[12:11];
    end
  end

  // Interrupt enable register
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      mieVal <= '0;
    end else if (writeIe) begin
      mieVal <= acc.wrData[11:0];
    end
  end

  // Unimplemented fields read zero
  assign mstatusVal  = {19'b0, statMpp, 3'b0, statMpie, 3'b0, statMie, 3'b0};
  assign globalIntEn = statMie;

endmodule

// File: logic/csrTop.sv
`timescale 1ns/1ps

module csrTop (
  input  logic           clk,
  input  logic           rstN,
  // Wishbone classic slave
  input  logic           wbCyc,
  input  logic           wbStb,
  input  logic           wbWe,
  input  csrPkg::csrAdr  wbAdr,
  input  csrPkg::csrWord wbDatW,
  output csrPkg::csrWord wbDatR,
  output logic           wbAck,
  output logic           wbErr,
  // Trap interface from the pipeline
  input  logic           trap,
  input  csrPkg::csrWord nextEpc,
  input  logic [4:0]     nextCause,
  input  csrPkg::csrWord nextTval,
  input  logic           mret,
  input  logic [11:0]    mip,
  // State seen by the hart
  output csrPkg::csrWord mtvec,
  output csrPkg::csrWord mepc,
  output logic           globalIntEn
);

  csrPkg::csrWord mstatusVal;
  logic [11:0]    mieVal;
  logic           writeStatus;
  logic           writeIe;

  csrAccessIf acc ();

  csrWishbone uWishbone (.clk, .rstN, .wbCyc, .wbStb, .wbWe, .wbAdr, .wbDatW,
                         .wbDatR, .wbAck, .wbErr, .acc(acc));

  csrMachine uMachine (.clk, .rstN, .trap, .nextEpc, .nextCause, .nextTval,
                       .mstatusVal, .mieVal, .mip, .acc(acc),
                       .writeStatus, .writeIe, .mtvec, .mepc);

  // mstatus and mie live apart from the other registers
  csrStatus uStatus (.clk, .rstN, .trap, .mret, .writeStatus, .writeIe,
                     .acc(acc), .mstatusVal, .mieVal, .globalIntEn);

endmodule

// File: logic/csrWishbone.sv
`timescale 1ns/1ps

module csrWishbone (
  input  logic           clk,
  input  logic           rstN,
  input  logic           wbCyc,
  input  logic           wbStb,
  input  logic           wbWe,
  input  csrPkg::csrAdr  wbAdr,
  input  csrPkg::csrWord wbDatW,
  output csrPkg::csrWord wbDatR,
  output logic           wbAck,
  output logic           wbErr,
  csrAccessIf.bus        acc
);

  logic start;

  // New access only when not terminating the previous one
  // Held strobe during ack or err is ignored
  assign start = wbCyc & wbStb & ~wbAck & ~wbErr;

  // Access lasts exactly the strobe cycle
  assign acc.req    = start;
  assign acc.write  = wbWe;
  assign acc.adr    = wbAdr;
  assign acc.wrData = wbDatW;

  ////////////////////////////////////////////////////////////////////////////
  // Termination
  ////////////////////////////////////////////////////////////////////////////

  // One-cycle ack or err, chosen by the illegal flag
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      wbAck <= 1'b0;
      wbErr <= 1'b0;
    end else begin
      wbAck <= start & ~acc.illegal;
      wbErr <= start & acc.illegal;
    end
  end

  // Read data captured with the termination
  always_ff @(posedge clk) begin
    if (start) begin
      // Error cycles return zero
      wbDatR <= acc.illegal ? '0 : acc.rdData;
    end
  end

endmodule

// File: tests/csrTb.sv
`timescale 1ns/1ps

module csrTb;

  logic           clk;
  logic           rstN;
  logic           wbCyc;
  logic           wbStb;
  logic           wbWe;
  csrPkg::csrAdr  wbAdr;
  csrPkg::csrWord wbDatW;
  csrPkg::csrWord wbDatR;
  logic           wbAck;
  logic           wbErr;
  logic           trap;
  csrPkg::csrWord nextEpc;
  logic [4:0]     nextCause;
  csrPkg::csrWord nextTval;
  logic           mret;
  logic [11:0]    mip;
  csrPkg::csrWord mtvec;
  csrPkg::csrWord mepc;
  logic           globalIntEn;

  int seed    = 58819;
  int nChecks = 0;
  int nErrors = 0;

  csrTop UUT (.*);

  // 100 ns clock
  initial clk = 1'b0;
  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic checkWord(input string name, input csrPkg::csrWord got,
                           input csrPkg::csrWord exp);
    nChecks++;
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %h, expected %h", $time, name, got, exp);
      nErrors++;
    end
  endtask

  // Termination kind where 1 means wbErr
  task automatic checkTerm(input string name, input logic gotErr, input logic expErr);
    nChecks++;
    if (gotErr !== expErr) begin
      $display("[FAIL] %0t ns: %s ended with err %b, expected %b", $time, name, gotErr,
               expErr);
      nErrors++;
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    nChecks++;
    if (got !== exp) begin
      $display("[FAIL] %0t ns: %s is %b, expected %b", $time, name, got, exp);
      nErrors++;
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Wishbone master tasks
  ////////////////////////////////////////////////////////////////////////////

  // Polls 10 ns after each edge for at most 20 cycles
  task automatic awaitTermination(output logic isErr, output csrPkg::csrWord data);
    int cycles;
    cycles = 0;
    isErr  = 1'b0;
    data   = '0;
    do begin
      @(posedge clk);
      #10;
      cycles++;
    end while (!wbAck && !wbErr && cycles < 20);
    if (wbAck || wbErr) begin
      isErr = wbErr;
      data  = wbDatR;
    end else begin
      $display("Timeout: no Wishbone ack or err within 20 cycles at address %h", wbAdr);
      nErrors++;
    end
    // Strobe drops right after termination
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic wbWrite(input csrPkg::csrAdr adr, input csrPkg::csrWord data,
                         output logic isErr);
    csrPkg::csrWord unused;
    @(posedge clk);
    #10;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = adr;
    wbDatW = data;
    awaitTermination(isErr, unused);
  endtask

  task automatic wbRead(input csrPkg::csrAdr adr, output csrPkg::csrWord data,
                        output logic isErr);
    @(posedge clk);
    #10;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe  = 1'b0;
    wbAdr = adr;
    awaitTermination(isErr, data);
  endtask

  task automatic readExpect(input string name, input csrPkg::csrAdr adr,
                            input csrPkg::csrWord exp);
    csrPkg::csrWord data;
    logic           isErr;
    wbRead(adr, data, isErr);
    checkTerm(name, isErr, 1'b0);
    checkWord(name, data, exp);
  endtask

  task automatic writeExpect(input string name, input csrPkg::csrAdr adr,
                             input csrPkg::csrWord data, input logic expErr);
    logic isErr;
    wbWrite(adr, data, isErr);
    checkTerm(name, isErr, expErr);
  endtask

  task automatic finishTest(input string name, input int startErrors);
    $display("%s finished with %0d errors", name, nErrors - startErrors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic identityReset();
    int startErrors;
    startErrors = nErrors;
    // MXL=1 with the I and S extension bits
    readExpect("misa", csrPkg::adrMisa, 32'h4004_0100);
    readExpect("mimpid", csrPkg::adrMimpid, 32'h0000_0100);
    readExpect("mvendorid", csrPkg::adrMvendorid, '0);
    readExpect("marchid", csrPkg::adrMarchid, '0);
    readExpect("mhartid", csrPkg::adrMhartid, '0);
    readExpect("mscratch reset", csrPkg::adrMscratch, '0);
    // Identity registers are read only
    writeExpect("mvendorid write", csrPkg::adrMvendorid, $random(seed), 1'b1);
    readExpect("mvendorid after write", csrPkg::adrMvendorid, '0);
    finishTest("Identity and reset", startErrors);
  endtask

  task automatic registerReadback();
    int             startErrors;
    csrPkg::csrWord d;
    startErrors = nErrors;
    d = $random(seed);
    writeExpect("mscratch write", csrPkg::adrMscratch, d, 1'b0);
    readExpect("mscratch", csrPkg::adrMscratch, d);
    // Bit 1 of mtvec never sticks
    d = $random(seed);
    writeExpect("mtvec write", csrPkg::adrMtvec, d, 1'b0);
    readExpect("mtvec", csrPkg::adrMtvec, d & ~32'h2);
    checkWord("mtvec port", mtvec, d & ~32'h2);
    d = $random(seed);
    writeExpect("medeleg write", csrPkg::adrMedeleg, d, 1'b0);
    readExpect("medeleg", csrPkg::adrMedeleg, d & 32'h0000_B3FF);
    d = $random(seed);
    writeExpect("mideleg write", csrPkg::adrMideleg, d, 1'b0);
    readExpect("mideleg", csrPkg::adrMideleg, d & 32'h0000_0222);
    finishTest("Register readback", startErrors);
  endtask

  task automatic trapAndMret();
    int             startErrors;
    csrPkg::csrWord epc;
    csrPkg::csrWord tval;
    logic [4:0]     cause;
    startErrors = nErrors;
    epc   = $random(seed);
    tval  = $random(seed);
    // Bit 4 marks an interrupt
    cause = {1'b1, 4'($random(seed))};
    writeExpect("mstatus MIE write", csrPkg::adrMstatus, 32'h0000_0008, 1'b0);
    checkFlag("globalIntEn before trap", globalIntEn, 1'b1);
    @(posedge clk);
    #10;
    trap      = 1'b1;
    nextEpc   = epc;
    nextCause = cause;
    nextTval  = tval;
    @(posedge clk);
    #10;
    trap = 1'b0;
    checkFlag("globalIntEn after trap", globalIntEn, 1'b0);
    checkWord("mepc port", mepc, epc);
    readExpect("mepc", csrPkg::adrMepc, epc);
    readExpect("mtval", csrPkg::adrMtval, tval);
    readExpect("mcause", csrPkg::adrMcause, {1'b1, 27'b0, cause[3:0]});
    // MPP = 3, MPIE = 1, MIE = 0
    readExpect("mstatus after trap", csrPkg::adrMstatus, 32'h0000_1880);
    @(posedge clk);
    #10;
    mret = 1'b1;
    @(posedge clk);
    #10;
    mret = 1'b0;
    checkFlag("globalIntEn after mret", globalIntEn, 1'b1);
    readExpect("mstatus after mret", csrPkg::adrMstatus, 32'h0000_1888);
    finishTest("Trap and mret", startErrors);
  endtask

  task automatic pmpLocking();
    int             startErrors;
    csrPkg::csrWord a0;
    csrPkg::csrWord a1;
    csrPkg::csrWord a2;
    startErrors = nErrors;
    a0 = $random(seed);
    a1 = $random(seed);
    a2 = $random(seed);
    writeExpect("pmpaddr0 write", csrPkg::adrPmpaddr0, a0, 1'b0);
    writeExpect("pmpaddr1 write", csrPkg::adrPmpaddr0 + 12'd1, a1, 1'b0);
    // Entry 1 locked TOR with r and entry 0 unlocked with r
    writeExpect("pmpcfg0 lock", csrPkg::adrPmpcfg0, 32'h0000_8901, 1'b0);
    readExpect("pmpcfg0", csrPkg::adrPmpcfg0, 32'h0000_8901);
    // Locked writes still terminate with ack
    writeExpect("pmpaddr0 locked write", csrPkg::adrPmpaddr0, ~a0, 1'b0);
    writeExpect("pmpaddr1 locked write", csrPkg::adrPmpaddr0 + 12'd1, ~a1, 1'b0);
    readExpect("pmpaddr0 kept", csrPkg::adrPmpaddr0, a0);
    readExpect("pmpaddr1 kept", csrPkg::adrPmpaddr0 + 12'd1, a1);
    writeExpect("pmpaddr2 write", csrPkg::adrPmpaddr0 + 12'd2, a2, 1'b0);
    readExpect("pmpaddr2", csrPkg::adrPmpaddr0 + 12'd2, a2);
    // Byte 1 keeps its locked value
    writeExpect("pmpcfg0 rewrite", csrPkg::adrPmpcfg0, 32'h0F0F_0F0F, 1'b0);
    readExpect("pmpcfg0 after rewrite", csrPkg::adrPmpcfg0, 32'h0F0F_890F);
    finishTest("PMP locking", startErrors);
  endtask

  task automatic unknownAddress();
    int             startErrors;
    csrPkg::csrWord d;
    csrPkg::csrWord data;
    logic           isErr;
    startErrors = nErrors;
    d = $random(seed);
    writeExpect("mscratch write", csrPkg::adrMscratch, d, 1'b0);
    // 0x7C0 is not a CSR of this block
    wbRead(12'h7C0, data, isErr);
    checkTerm("unknown read", isErr, 1'b1);
    checkWord("unknown read data", data, '0);
    readExpect("mscratch unchanged", csrPkg::adrMscratch, d);
    finishTest("Unknown address", startErrors);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    rstN      = 1'b1;
    wbCyc     = 1'b0;
    wbStb     = 1'b0;
    wbWe      = 1'b0;
    wbAdr     = '0;
    wbDatW    = '0;
    trap      = 1'b0;
    nextEpc   = '0;
    nextCause = '0;
    nextTval  = '0;
    mret      = 1'b0;
    mip       = '0;
    // Falling edge of rstN clears every register
    #1;
    rstN = 1'b0;
    // Reset held for 5 cycles
    repeat (5) @(posedge clk);
    #10;
    rstN = 1'b1;
    identityReset();
    registerReadback();
    trapAndMret();
    pmpLocking();
    unknownAddress();
    // Failures of the bound assertions
    nErrors += UUT.uWishbone.uAsserts.failCount;
    $display("Checks run: %0d, errors: %0d", nChecks, nErrors);
    if (nErrors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: tests/csrTb_asserts.sv
`timescale 1ns/1ps

module csrTbAsserts (
  input logic clk,
  input logic rstN,
  input logic wbStb,
  input logic wbAck,
  input logic wbErr
);

  // Number of failed assertions
  int failCount = 0;

  // Only one termination per bus cycle
  assert property (@(posedge clk) disable iff (!rstN) !(wbAck && wbErr))
    else begin
      $error("wbAck and wbErr high in the same cycle");
      failCount++;
    end

  // Termination is a one-cycle pulse once the master drops the strobe
  assert property (@(posedge clk) disable iff (!rstN)
    ((wbAck || wbErr) && !wbStb) |=> (!wbAck && !wbErr))
    else begin
      $error("Termination flag held longer than one cycle");
      failCount++;
    end

  // Both flags stay low in reset
  assert property (@(posedge clk) !rstN |-> (!wbAck && !wbErr))
    else begin
      $error("Termination flag high during reset");
      failCount++;
    end

endmodule

bind csrWishbone csrTbAsserts uAsserts (.clk, .rstN, .wbStb, .wbAck, .wbErr);
